//--- common/rp_cfg.svh
//////////////////////////////////////////////////
// fast analog path configuration
//////////////////////////////////////////////////

`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// datapath widths
`define RP_SMP_W            14          // adc and dac sample
`define RP_PIN_W            16          // adc pins, low 2 reserved
`define RP_BUS_W            32          // system bus data and address

// region field inside the bus address
`define RP_REG_LSB          20
`define RP_REG_MSB          22

`define RP_HK_ID            32'h5250_0101   // board id word

// housekeeping region offsets
`define RP_HK_ID_OFS        20'h00000
`define RP_HK_LOOP_OFS      20'h00004   // bit 0 is digital loop
`define RP_HK_LED_OFS       20'h00008
`define RP_HK_EXP_DIR_OFS   20'h00010   // 1 means pin drives out
`define RP_HK_EXP_OUT_OFS   20'h00014
`define RP_HK_EXP_IN_OFS    20'h00018   // read only

// analog region offsets
`define RP_AN_ADC_A_OFS     20'h00000   // read only
`define RP_AN_ADC_B_OFS     20'h00004   // read only
`define RP_AN_LVL_A_OFS     20'h00010
`define RP_AN_LVL_B_OFS     20'h00014
`define RP_AN_OFS_A_OFS     20'h00018
`define RP_AN_OFS_B_OFS     20'h0001C

`endif

//--- common/rp_bus_pkg.sv
//////////////////////////////////////////////////
// system bus types
//////////////////////////////////////////////////

`default_nettype none

`include "rp_cfg.svh"

package rp_bus_pkg;

  typedef logic [`RP_BUS_W-1:0]   bus_word_t;   // read and write data
  typedef logic [`RP_BUS_W-1:0]   bus_addr_t;   // byte address
  typedef logic [`RP_REG_LSB-1:0] bus_ofs_t;    // offset inside one region

  // eight regions, selected by address bits 22..20
  typedef enum logic [`RP_REG_MSB-`RP_REG_LSB:0] {
    REG_HK      = 3'd0,   // housekeeping
    REG_ANALOG  = 3'd1,   // adc readback, dac levels
    REG_FREE2   = 3'd2,
    REG_FREE3   = 3'd3,
    REG_FREE4   = 3'd4,
    REG_FREE5   = 3'd5,
    REG_FREE6   = 3'd6,
    REG_FREE7   = 3'd7
  } bus_region_e;

  // region field of an address
  function automatic bus_region_e region_of(input bus_addr_t addr);
    region_of = bus_region_e'(addr[`RP_REG_MSB:`RP_REG_LSB]);
  endfunction

  // offset below the region field
  function automatic bus_ofs_t offset_of(input bus_addr_t addr);
    offset_of = addr[`RP_REG_LSB-1:0];
  endfunction

endpackage

`default_nettype wire

//--- common/rp_sig_pkg.sv
//////////////////////////////////////////////////
// sample and code types
//////////////////////////////////////////////////

`default_nettype none

`include "rp_cfg.svh"

package rp_sig_pkg;

  // converter code, unsigned with negative slope
  typedef logic [`RP_SMP_W-1:0]        adc_raw_t;

  typedef logic signed [`RP_SMP_W-1:0] smp_t;     // two's complement sample

  typedef logic signed [`RP_SMP_W:0]   dac_sum_t; // level plus offset, one guard bit

  // code to sample: keep msb, flip the rest
  function automatic smp_t raw_to_smp(input adc_raw_t code);
    raw_to_smp = {code[`RP_SMP_W-1], ~code[`RP_SMP_W-2:0]};
  endfunction

  // sample back to code, same bit flip
  // 0 maps to 0x1fff, mid scale on the converter
  function automatic adc_raw_t smp_to_raw(input smp_t smp);
    smp_to_raw = {smp[`RP_SMP_W-1], ~smp[`RP_SMP_W-2:0]};
  endfunction

endpackage

`default_nettype wire

//--- hw/adc/adc_frontend.sv
//////////////////////////////////////////////////
// adc capture and loopback
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module adc_frontend
  import rp_sig_pkg::*;
(
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  input  wire [`RP_PIN_W-1:0]  adc_dat_a_i,
  input  wire [`RP_PIN_W-1:0]  adc_dat_b_i,
  input  wire                  digital_loop_i,   // 1 = take dac samples
  input  wire smp_t            dac_a_i,
  input  wire smp_t            dac_b_i,
  output smp_t                 adc_a_o,
  output smp_t                 adc_b_o
);

  localparam int RSV_W = `RP_PIN_W - `RP_SMP_W;  // reserved low pin bits

  adc_raw_t adc_dat_a_q;    // pin capture, ch a
  adc_raw_t adc_dat_b_q;    // pin capture, ch b

  //////////////////////////////////////////////////
  // input register
  //////////////////////////////////////////////////

  // should map onto io block flops
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_dat_a_q <= '0;
      adc_dat_b_q <= '0;
    end
    else
    begin
      adc_dat_a_q <= adc_dat_a_i[`RP_PIN_W-1:RSV_W];  // drop bits 1..0
      adc_dat_b_q <= adc_dat_b_i[`RP_PIN_W-1:RSV_W];
    end
  end

  // negative slope code to two's complement, or the dac path in loop mode
  assign adc_a_o = digital_loop_i ? dac_a_i : raw_to_smp(adc_dat_a_q);
  assign adc_b_o = digital_loop_i ? dac_b_i : raw_to_smp(adc_dat_b_q);

endmodule

`default_nettype wire

//--- hw/dac/dac_backend.sv
//////////////////////////////////////////////////
// dac summation and output register
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module dac_backend
  import rp_sig_pkg::*;
(
  input  wire        adc_clk,
  input  wire        rst_n_i,
  input  wire smp_t  lvl_a_i,
  input  wire smp_t  lvl_b_i,
  input  wire smp_t  ofs_a_i,
  input  wire smp_t  ofs_b_i,
  output smp_t       dac_a_o,       // saturated, also fed to loopback
  output smp_t       dac_b_o,
  output adc_raw_t   dac_dat_a_o,   // pin code, negative slope
  output adc_raw_t   dac_dat_b_o
);

  // pin code for a zero sample
  localparam adc_raw_t DAC_IDLE = smp_to_raw(smp_t'(0));

  // clip a 15 bit sum to the 14 bit range
  // top two bits differ means overflow, sign picks the rail
  function automatic smp_t saturate(input dac_sum_t sum);
    if (sum[`RP_SMP_W] ^ sum[`RP_SMP_W-1])
      saturate = {sum[`RP_SMP_W], {(`RP_SMP_W-1){~sum[`RP_SMP_W]}}};
    else
      saturate = sum[`RP_SMP_W-1:0];
  endfunction

  dac_sum_t sum_a;
  dac_sum_t sum_b;

  //////////////////////////////////////////////////
  // level plus offset
  //////////////////////////////////////////////////

  // one bit of sign extension on each operand
  assign sum_a = {lvl_a_i[`RP_SMP_W-1], lvl_a_i} + {ofs_a_i[`RP_SMP_W-1], ofs_a_i};
  assign sum_b = {lvl_b_i[`RP_SMP_W-1], lvl_b_i} + {ofs_b_i[`RP_SMP_W-1], ofs_b_i};

  assign dac_a_o = saturate(sum_a);   // +8191 / -8192 rails
  assign dac_b_o = saturate(sum_b);

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////

  // signed back to converter code, one cycle after the registers
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= DAC_IDLE;      // mid scale
      dac_dat_b_o <= DAC_IDLE;
    end
    else
    begin
      dac_dat_a_o <= smp_to_raw(dac_a_o);
      dac_dat_b_o <= smp_to_raw(dac_b_o);
    end
  end

endmodule

`default_nettype wire

//--- hw/sys_bus_ctrl.sv
//////////////////////////////////////////////////
// system bus decoder and register regions
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module sys_bus_ctrl
  import rp_bus_pkg::*, rp_sig_pkg::*;
(
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  // bus request side
  input  wire bus_addr_t       sys_addr_i,
  input  wire bus_word_t       sys_wdata_i,
  input  wire                  sys_wen_i,
  input  wire                  sys_ren_i,
  // status in
  input  wire smp_t            adc_a_i,
  input  wire smp_t            adc_b_i,
  input  wire [7:0]            exp_in_i,
  // bus answer side
  output bus_word_t            sys_rdata_o,    // valid with ack
  output logic                 sys_ack_o,
  output logic                 sys_err_o,
  // housekeeping outputs
  output logic                 digital_loop_o,
  output logic [7:0]           led_o,
  output logic [7:0]           exp_dir_o,
  output logic [7:0]           exp_out_o,
  // analog outputs
  output smp_t                 lvl_a_o,
  output smp_t                 lvl_b_o,
  output smp_t                 ofs_a_o,
  output smp_t                 ofs_b_o
);

  // widen a sample to a bus word, sign kept
  function automatic bus_word_t sext_smp(input smp_t smp);
    sext_smp = {{(`RP_BUS_W-`RP_SMP_W){smp[`RP_SMP_W-1]}}, smp};
  endfunction

  bus_region_e region;      // addr 22..20
  bus_ofs_t    ofs;         // addr 19..0
  logic        hk_wen;      // write into housekeeping
  logic        an_wen;      // write into analog
  bus_word_t   hk_rdata;
  bus_word_t   an_rdata;
  bus_word_t   rdata_d;     // selected region read word

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  assign region = region_of(sys_addr_i);
  assign ofs    = offset_of(sys_addr_i);

  assign hk_wen = sys_wen_i && (region == REG_HK);
  assign an_wen = sys_wen_i && (region == REG_ANALOG);  // regions 2..7 never write

  //////////////////////////////////////////////////
  // housekeeping region
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
      exp_dir_o      <= '0;    // all expansion pins start as inputs
      exp_out_o      <= '0;
    end
    else if (hk_wen)
    begin
      case (ofs)
        `RP_HK_LOOP_OFS:    digital_loop_o <= sys_wdata_i[0];
        `RP_HK_LED_OFS:     led_o          <= sys_wdata_i[7:0];
        `RP_HK_EXP_DIR_OFS: exp_dir_o      <= sys_wdata_i[7:0];
        `RP_HK_EXP_OUT_OFS: exp_out_o      <= sys_wdata_i[7:0];
        default: ;           // id and exp_in are read only
      endcase
    end
  end

  always_comb
  begin
    hk_rdata = '0;
    case (ofs)
      `RP_HK_ID_OFS:      hk_rdata       = `RP_HK_ID;
      `RP_HK_LOOP_OFS:    hk_rdata[0]    = digital_loop_o;
      `RP_HK_LED_OFS:     hk_rdata[7:0]  = led_o;
      `RP_HK_EXP_DIR_OFS: hk_rdata[7:0]  = exp_dir_o;
      `RP_HK_EXP_OUT_OFS: hk_rdata[7:0]  = exp_out_o;
      `RP_HK_EXP_IN_OFS:  hk_rdata[7:0]  = exp_in_i;   // live pin value
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // analog region
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      lvl_a_o <= '0;
      lvl_b_o <= '0;
      ofs_a_o <= '0;
      ofs_b_o <= '0;
    end
    else if (an_wen)
    begin
      // only the low 14 bits are kept
      case (ofs)
        `RP_AN_LVL_A_OFS: lvl_a_o <= sys_wdata_i[`RP_SMP_W-1:0];
        `RP_AN_LVL_B_OFS: lvl_b_o <= sys_wdata_i[`RP_SMP_W-1:0];
        `RP_AN_OFS_A_OFS: ofs_a_o <= sys_wdata_i[`RP_SMP_W-1:0];
        `RP_AN_OFS_B_OFS: ofs_b_o <= sys_wdata_i[`RP_SMP_W-1:0];
        default: ;
      endcase
    end
  end

  always_comb
  begin
    case (ofs)
      `RP_AN_ADC_A_OFS: an_rdata = sext_smp(adc_a_i);
      `RP_AN_ADC_B_OFS: an_rdata = sext_smp(adc_b_i);
      `RP_AN_LVL_A_OFS: an_rdata = sext_smp(lvl_a_o);
      `RP_AN_LVL_B_OFS: an_rdata = sext_smp(lvl_b_o);
      `RP_AN_OFS_A_OFS: an_rdata = sext_smp(ofs_a_o);
      `RP_AN_OFS_B_OFS: an_rdata = sext_smp(ofs_b_o);
      default:          an_rdata = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // read mux and acknowledge
  //////////////////////////////////////////////////

  always_comb
  begin
    case (region)
      REG_HK:     rdata_d = hk_rdata;
      REG_ANALOG: rdata_d = an_rdata;
      default:    rdata_d = '0;     // free regions read zero
    endcase
  end

  // every request is answered one cycle later, any region
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      sys_ack_o <= 1'b0;
    else
      sys_ack_o <= sys_wen_i | sys_ren_i;
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
      sys_rdata_o <= rdata_d;   // held until next read
  end

  assign sys_err_o = 1'b0;      // no bus errors in this map

endmodule

`default_nettype wire

//--- hw/rp_top.sv
//////////////////////////////////////////////////
// fast analog path top level
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module rp_top
  import rp_bus_pkg::*, rp_sig_pkg::*;
(
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  // adc pins
  input  wire [`RP_PIN_W-1:0]  adc_dat_a_i,    // ch a, bits 1..0 reserved
  input  wire [`RP_PIN_W-1:0]  adc_dat_b_i,    // ch b
  // system bus
  input  wire bus_addr_t       sys_addr_i,
  input  wire bus_word_t       sys_wdata_i,
  input  wire                  sys_wen_i,      // single cycle pulse
  input  wire                  sys_ren_i,      // single cycle pulse
  input  wire [7:0]            exp_in_i,       // expansion port in
  output bus_word_t            sys_rdata_o,
  output logic                 sys_ack_o,
  output logic                 sys_err_o,
  // dac pins, one bus per channel
  output adc_raw_t             dac_dat_a_o,
  output adc_raw_t             dac_dat_b_o,
  // board io
  output logic [7:0]           led_o,
  output logic [7:0]           exp_dir_o,
  output logic [7:0]           exp_out_o
);

  smp_t adc_a, adc_b;   // samples after conversion or loop
  smp_t dac_a, dac_b;   // saturated dac samples
  smp_t lvl_a, lvl_b;   // dac levels from registers
  smp_t ofs_a, ofs_b;   // dac offsets from registers
  logic digital_loop;

  //////////////////////////////////////////////////
  // bus decoder and register regions
  //////////////////////////////////////////////////

  sys_bus_ctrl u_bus (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .adc_a_i        (adc_a),         // readback
    .adc_b_i        (adc_b),
    .exp_in_i       (exp_in_i),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .sys_err_o      (sys_err_o),
    .digital_loop_o (digital_loop),
    .led_o          (led_o),
    .exp_dir_o      (exp_dir_o),
    .exp_out_o      (exp_out_o),
    .lvl_a_o        (lvl_a),
    .lvl_b_o        (lvl_b),
    .ofs_a_o        (ofs_a),
    .ofs_b_o        (ofs_b)
  );

  //////////////////////////////////////////////////
  // adc capture and dac output
  //////////////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),         // loopback source
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  dac_backend u_dac (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .lvl_a_i        (lvl_a),
    .lvl_b_i        (lvl_b),
    .ofs_a_i        (ofs_a),
    .ofs_b_i        (ofs_b),
    .dac_a_o        (dac_a),
    .dac_b_o        (dac_b),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_rp_top.sv
//////////////////////////////////////////////////
// fast analog path testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rp_cfg.svh"

module tb_rp_top
  import rp_bus_pkg::*, rp_sig_pkg::*;
();

  localparam int ACK_TIMEOUT = 16;    // cycles to wait for ack

  logic                 adc_clk;
  logic                 rst_n_i;
  logic [`RP_PIN_W-1:0] adc_dat_a_i;
  logic [`RP_PIN_W-1:0] adc_dat_b_i;
  bus_addr_t            sys_addr_i;
  bus_word_t            sys_wdata_i;
  logic                 sys_wen_i;
  logic                 sys_ren_i;
  logic [7:0]           exp_in_i;
  bus_word_t            sys_rdata_o;
  logic                 sys_ack_o;
  logic                 sys_err_o;
  adc_raw_t             dac_dat_a_o;
  adc_raw_t             dac_dat_b_o;
  logic [7:0]           led_o;
  logic [7:0]           exp_dir_o;
  logic [7:0]           exp_out_o;

  int     errors;
  int     checks;
  int     timeouts;
  integer seed;
  logic [7:0] led_val;      // last led write, for region 2..7 test
  int     lvl_a_val;        // last level written on ch a
  int     sat_a, sat_b;     // expected saturated dac samples

  rp_top dut_i (.*);

  always #20 adc_clk = ~adc_clk;    // 40 ns period

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic bus_addr_t make_addr(input int region, input logic [19:0] ofs);
    make_addr = {9'd0, region[2:0], ofs};   // bits 22..20 pick the region
  endfunction

  function automatic int clamp_sum(input int s);
    if (s > 8191)
      clamp_sum = 8191;
    else if (s < -8192)
      clamp_sum = -8192;
    else
      clamp_sum = s;
  endfunction

  // signed sample to pin code, msb kept, 13 bits flipped
  function automatic adc_raw_t neg_slope_code(input int s);
    logic [13:0] bits;
    bits = s[13:0];
    neg_slope_code = bits ^ 14'h1FFF;
  endfunction

  function automatic int code_to_sample(input logic [13:0] code);
    logic signed [13:0] v;
    v = code ^ 14'h1FFF;
    code_to_sample = v;     // sign extends into int
  endfunction

  // any 14 bit signed value
  function automatic int random_sample();
    logic [13:0] r;
    r = $random(seed);
    random_sample = $signed(r);
  endfunction

  task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  // ack is sampled on falling edges, where it is stable
  // due at the first falling edge after the request
  task automatic wait_ack(input bus_addr_t addr);
    int n;
    n = 0;
    while (!sys_ack_o && n < ACK_TIMEOUT)
    begin
      @(negedge adc_clk);
      n++;
    end
    if (!sys_ack_o)
    begin
      timeouts++;
      $display("no bus acknowledge for address %h within %0d cycles", addr, n);
    end
    else if (n != 0)
    begin
      errors++;
      $display("bus acknowledge for address %h came %0d cycles late", addr, n);
    end
    else if (sys_err_o !== 1'b0)
    begin
      errors++;
      $display("bus error raised for address %h", addr);
    end
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_word_t data);
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;       // single cycle pulse
    @(negedge adc_clk);
    sys_wen_i   = 1'b0;
    wait_ack(addr);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_word_t data);
    @(negedge adc_clk);
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    @(negedge adc_clk);
    sys_ren_i  = 1'b0;
    wait_ack(addr);
    data = sys_rdata_o;       // valid while ack is high
  endtask

  // program levels and offsets, then compare the pin codes
  task automatic apply_dac_case(input int lvl_a, input int ofs_a,
                                input int lvl_b, input int ofs_b);
    bus_write(make_addr(1, `RP_AN_LVL_A_OFS), bus_word_t'(lvl_a));
    bus_write(make_addr(1, `RP_AN_OFS_A_OFS), bus_word_t'(ofs_a));
    bus_write(make_addr(1, `RP_AN_LVL_B_OFS), bus_word_t'(lvl_b));
    bus_write(make_addr(1, `RP_AN_OFS_B_OFS), bus_word_t'(ofs_b));
    repeat (2) @(negedge adc_clk);
    sat_a     = clamp_sum(lvl_a + ofs_a);
    sat_b     = clamp_sum(lvl_b + ofs_b);
    lvl_a_val = lvl_a;
    check_word("dac sat a", neg_slope_code(sat_a), dac_dat_a_o);
    check_word("dac sat b", neg_slope_code(sat_b), dac_dat_b_o);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_reset_id();
    bus_word_t rd;
    check_word("reset dac a", 32'h1FFF, dac_dat_a_o);   // sample 0 code
    check_word("reset dac b", 32'h1FFF, dac_dat_b_o);
    check_word("reset led", 32'h0, led_o);
    check_word("reset exp dir", 32'h0, exp_dir_o);
    bus_read(make_addr(0, `RP_HK_ID_OFS), rd);
    check_word("hk id", `RP_HK_ID, rd);
  endtask

  task automatic test_hk_regs();
    bus_word_t  rd;
    logic [7:0] dir_val, out_val, in_val;
    led_val = $random(seed);
    dir_val = $random(seed);
    out_val = $random(seed);
    bus_write(make_addr(0, `RP_HK_LED_OFS), {24'd0, led_val});
    bus_write(make_addr(0, `RP_HK_EXP_DIR_OFS), {24'd0, dir_val});
    bus_write(make_addr(0, `RP_HK_EXP_OUT_OFS), {24'd0, out_val});
    bus_read(make_addr(0, `RP_HK_LED_OFS), rd);
    check_word("hk led read", {24'd0, led_val}, rd);
    check_word("hk led pins", {24'd0, led_val}, led_o);
    bus_read(make_addr(0, `RP_HK_EXP_DIR_OFS), rd);
    check_word("hk dir read", {24'd0, dir_val}, rd);
    check_word("hk dir pins", {24'd0, dir_val}, exp_dir_o);
    bus_read(make_addr(0, `RP_HK_EXP_OUT_OFS), rd);
    check_word("hk out read", {24'd0, out_val}, rd);
    check_word("hk out pins", {24'd0, out_val}, exp_out_o);
    in_val = $random(seed);
    @(negedge adc_clk);
    exp_in_i = in_val;
    bus_read(make_addr(0, `RP_HK_EXP_IN_OFS), rd);
    check_word("hk exp in", {24'd0, in_val}, rd);
  endtask

  task automatic test_adc_conv();
    bus_word_t rd;
    for (int i = 0; i < 6; i++)
    begin
      @(negedge adc_clk);
      adc_dat_a_i = $random(seed);
      adc_dat_b_i = $random(seed);
      repeat (2) @(negedge adc_clk);    // pin to sample is one edge
      bus_read(make_addr(1, `RP_AN_ADC_A_OFS), rd);
      check_word("adc conv a", bus_word_t'(code_to_sample(adc_dat_a_i[15:2])), rd);
      bus_read(make_addr(1, `RP_AN_ADC_B_OFS), rd);
      check_word("adc conv b", bus_word_t'(code_to_sample(adc_dat_b_i[15:2])), rd);
    end
  endtask

  task automatic test_dac_sat();
    apply_dac_case(8191, 8191, -8192, -8192);   // both rails
    apply_dac_case(-8192, -1, 8191, 1);
    apply_dac_case(8191, -8192, -8192, 8191);   // extremes cancel
    for (int i = 0; i < 3; i++)
      apply_dac_case(random_sample(), random_sample(), random_sample(), random_sample());
  endtask

  task automatic test_loopback();
    bus_word_t rd;
    bus_write(make_addr(0, `RP_HK_LOOP_OFS), 32'h1);
    @(negedge adc_clk);
    adc_dat_a_i = $random(seed);      // pins must be ignored
    adc_dat_b_i = $random(seed);
    repeat (2) @(negedge adc_clk);
    bus_read(make_addr(1, `RP_AN_ADC_A_OFS), rd);
    check_word("loop a", bus_word_t'(sat_a), rd);
    bus_read(make_addr(1, `RP_AN_ADC_B_OFS), rd);
    check_word("loop b", bus_word_t'(sat_b), rd);
    bus_write(make_addr(0, `RP_HK_LOOP_OFS), 32'h0);
  endtask

  task automatic test_unused_regions();
    bus_word_t rd;
    for (int r = 2; r < 8; r++)
    begin
      bus_write(make_addr(r, `RP_HK_LED_OFS), $random(seed));
      bus_write(make_addr(r, `RP_AN_LVL_A_OFS), $random(seed));
      bus_read(make_addr(r, `RP_HK_ID_OFS), rd);      // id would leak here
      check_word("free region read", 32'h0, rd);
      bus_read(make_addr(r, `RP_HK_LED_OFS), rd);
      check_word("free region read", 32'h0, rd);
    end
    check_word("free led kept", {24'd0, led_val}, led_o);
    bus_read(make_addr(1, `RP_AN_LVL_A_OFS), rd);
    check_word("free lvl kept", bus_word_t'(lvl_a_val), rd);
    check_word("free dac kept", neg_slope_code(sat_a), dac_dat_a_o);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    seed        = 32'hc2a5;
    errors      = 0;
    checks      = 0;
    timeouts    = 0;
    adc_clk     = 1'b0;
    rst_n_i     = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    exp_in_i    = '0;
    repeat (5) @(negedge adc_clk);
    rst_n_i = 1'b1;
    test_reset_id();
    test_hk_regs();
    test_adc_conv();
    test_dac_sat();
    test_loopback();
    test_unused_regions();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- rp_top.f
+incdir+common
common/rp_bus_pkg.sv
common/rp_sig_pkg.sv
hw/adc/adc_frontend.sv
hw/dac/dac_backend.sv
hw/sys_bus_ctrl.sv
hw/rp_top.sv
tb/tb_rp_top.sv
